// File: hdl/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// Bus geometry shared by the package and the SRAM slave

// Word address width, one address per data word
`define WB_ADDR_W 8

// Data bus width
`define WB_DATA_W 32

// Number of SRAM words behind the slave
// Must not exceed 2**WB_ADDR_W
`define WB_MEM_DEPTH 256

`endif

// File: hdl/wb_pkg.sv
`default_nettype none

`include "wb_params.svh"

package wb_pkg;

  // Plain vectors for the widths that carry a meaning
  typedef logic [`WB_ADDR_W-1:0] wb_addr_t;  // Word address
  typedef logic [`WB_DATA_W-1:0] wb_data_t;  // Data word

  // Owner of the shared bus, encoding kept from the reference arbiter
  typedef enum logic [1:0] {
    PRIOR_MASTER = 2'b00,  // Master 0, highest priority
    MASTER_2     = 2'b01,  // Master 1
    MASTER_3     = 2'b10,  // Master 2, lowest priority
    NO_MASTER    = 2'b11   // Bus idle
  } master_sel_t;

  // Master to slave request fields
  typedef struct packed {
    logic     cyc;  // Bus cycle in progress
    logic     stb;  // Request strobe
    logic     we;   // Write enable
    wb_addr_t adr;
    wb_data_t dat;  // Write data
  } wb_req_t;

  // Slave to master response fields
  typedef struct packed {
    logic     ack;    // One per accepted request
    logic     stall;  // Request not taken this cycle
    wb_data_t dat;    // Read data, valid with ack
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/wb_priority_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_priority_arbiter
  import wb_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  // Master side
  input  wire wb_req_t m0_req_i,  // Highest priority
  input  wire wb_req_t m1_req_i,
  input  wire wb_req_t m2_req_i,  // Lowest priority
  output wb_rsp_t      m0_rsp_o,
  output wb_rsp_t      m1_rsp_o,
  output wb_rsp_t      m2_rsp_o,
  // Slave side
  output wb_req_t      s_req_o,
  input  wire wb_rsp_t s_rsp_i
);

  localparam int NUM_MASTERS = 3;

  master_sel_t             grant_q;   // Current bus owner
  master_sel_t             grant_d;
  logic [NUM_MASTERS-1:0]  cyc_vec;   // Pending cycles, bit 0 is master 0
  logic                    owner_busy;
  wb_rsp_t                 m_rsp [NUM_MASTERS];

  assign cyc_vec = {m2_req_i.cyc, m1_req_i.cyc, m0_req_i.cyc};

  // Owner still inside its bus cycle
  always_comb begin
    case (grant_q)
      PRIOR_MASTER: owner_busy = cyc_vec[0];
      MASTER_2:     owner_busy = cyc_vec[1];
      MASTER_3:     owner_busy = cyc_vec[2];
      default:      owner_busy = 1'b0;
    endcase
  end

  // Next owner by fixed priority, no preemption
  always_comb begin
    if (owner_busy) begin
      grant_d = grant_q;  // Hold until the owner drops cyc
    end else if (cyc_vec[0]) begin
      grant_d = PRIOR_MASTER;
    end else if (cyc_vec[1]) begin
      grant_d = MASTER_2;
    end else if (cyc_vec[2]) begin
      grant_d = MASTER_3;
    end else begin
      grant_d = NO_MASTER;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grant_q <= NO_MASTER;
    end else begin
      grant_q <= grant_d;
    end
  end

  // Only the owner's request reaches the slave
  always_comb begin
    case (grant_q)
      PRIOR_MASTER: s_req_o = m0_req_i;
      MASTER_2:     s_req_o = m1_req_i;
      MASTER_3:     s_req_o = m2_req_i;
      default:      s_req_o = '0;  // Idle bus
    endcase
  end

  // Response steering
  // Read data goes to everyone, ack and stall follow the grant
  for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_rsp
    logic owned;

    assign owned = (grant_q == master_sel_t'(i));

    assign m_rsp[i] = '{
      ack:   owned & s_rsp_i.ack,
      stall: owned ? s_rsp_i.stall : 1'b1,  // Others wait
      dat:   s_rsp_i.dat
    };
  end

  assign m0_rsp_o = m_rsp[0];
  assign m1_rsp_o = m_rsp[1];
  assign m2_rsp_o = m_rsp[2];

endmodule

`default_nettype wire

// File: hdl/wb_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_sram_slave
  import wb_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire wb_req_t req_i,
  output wb_rsp_t      rsp_o
);

  // Payload of a request waiting in stage 1
  typedef struct packed {
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } s1_entry_t;

  wb_data_t  mem [`WB_MEM_DEPTH];

  logic      req_valid;   // Request on the bus this cycle
  logic      raw_hazard;  // Read behind a write to the same word
  logic      accept;

  logic      s1_valid;
  s1_entry_t s1_q;

  logic      ack_q;
  wb_data_t  rd_dat_q;

  assign req_valid = req_i.cyc & req_i.stb;

  // Read hitting the word that stage 1 is about to write
  assign raw_hazard = req_valid & ~req_i.we &
                      s1_valid & s1_q.we &
                      (s1_q.adr == req_i.adr);

  assign accept = req_valid & ~raw_hazard;

  // Control pipeline
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      s1_valid <= accept;
      ack_q    <= s1_valid;  // One ack per accepted request, in order
    end
  end

  // Stage 1 payload
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_q.we  <= req_i.we;
      s1_q.adr <= req_i.adr;
      s1_q.dat <= req_i.dat;
    end
  end

  // Stage 2, array access
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      if (s1_q.we) begin
        mem[s1_q.adr] <= s1_q.dat;
      end else begin
        rd_dat_q <= mem[s1_q.adr];
      end
    end
  end

  // Stall stays combinational so the held read goes in on the next edge
  assign rsp_o = '{
    ack:   ack_q,
    stall: raw_hazard,
    dat:   rd_dat_q
  };

endmodule

`default_nettype wire

// File: hdl/wb_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sys_top
  import wb_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire wb_req_t m0_req_i,  // Highest priority master
  input  wire wb_req_t m1_req_i,
  input  wire wb_req_t m2_req_i,  // Lowest priority master
  output wb_rsp_t      m0_rsp_o,
  output wb_rsp_t      m1_rsp_o,
  output wb_rsp_t      m2_rsp_o
);

  // Shared bus between arbiter and SRAM
  wb_req_t s_req;
  wb_rsp_t s_rsp;

  wb_priority_arbiter u_arbiter (
    .clk      (clk),
    .rst      (rst),
    .m0_req_i (m0_req_i),
    .m1_req_i (m1_req_i),
    .m2_req_i (m2_req_i),
    .m0_rsp_o (m0_rsp_o),
    .m1_rsp_o (m1_rsp_o),
    .m2_rsp_o (m2_rsp_o),
    .s_req_o  (s_req),
    .s_rsp_i  (s_rsp)
  );

  wb_sram_slave u_sram (
    .clk   (clk),
    .rst   (rst),
    .req_i (s_req),
    .rsp_o (s_rsp)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Wishbone system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  --top-module tb_wb_sys_top \
  --Mdir obj_dir \
  -o tb_wb_sys_top \
  -f wb_sys_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_wb_sys_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 50,  // 100 ns clock
  parameter int RESET_CYCLES   = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_wb_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module tb_wb_sys_top
  import wb_pkg::*;
();

  localparam int NUM_MASTERS   = 3;
  localparam int MAX_OPS       = 8;
  localparam int BUS_TIMEOUT   = 100;  // Cycles per bus cycle
  localparam int RESET_TIMEOUT = 10;

  logic    clk;
  logic    rst;
  wb_req_t m0_req;
  wb_req_t m1_req;
  wb_req_t m2_req;
  wb_rsp_t m0_rsp;
  wb_rsp_t m1_rsp;
  wb_rsp_t m2_rsp;

  integer   seed = 32'h4265ee28;
  wb_data_t mirror [`WB_MEM_DEPTH];  // Expected SRAM contents

  // Per-master operation lists, filled before each bus cycle
  logic     op_we   [NUM_MASTERS][MAX_OPS];
  wb_addr_t op_adr  [NUM_MASTERS][MAX_OPS];
  wb_data_t op_dat  [NUM_MASTERS][MAX_OPS];
  wb_data_t exp_dat [NUM_MASTERS][MAX_OPS];  // Read data in issue order

  time first_acc_t [NUM_MASTERS];
  time first_ack_t [NUM_MASTERS];
  time done_t      [NUM_MASTERS];  // Edge where cyc dropped
  int  late_stalls [NUM_MASTERS];  // Stalls after the first acceptance

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  wb_sys_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .m0_req_i (m0_req),
    .m1_req_i (m1_req),
    .m2_req_i (m2_req),
    .m0_rsp_o (m0_rsp),
    .m1_rsp_o (m1_rsp),
    .m2_rsp_o (m2_rsp)
  );

  task automatic abort_test(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      abort_test($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_test($sformatf("ERROR at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_test($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic drive_req(input int m, input wb_req_t req);
    case (m)
      0:       m0_req <= req;
      1:       m1_req <= req;
      default: m2_req <= req;
    endcase
  endtask

  function automatic wb_rsp_t rsp_of(input int m);
    case (m)
      0:       return m0_rsp;
      1:       return m1_rsp;
      default: return m2_rsp;
    endcase
  endfunction

  function automatic wb_req_t make_req(input int m, input int i);
    wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = op_we[m][i];
    req.adr = op_adr[m][i];
    req.dat = op_dat[m][i];
    return req;
  endfunction

  // Mirror follows issue order, so addresses of concurrent masters must differ
  task automatic plan_write(input int m, input int i, input wb_addr_t adr);
    wb_data_t word;
    word = $random(seed);
    op_we[m][i]  = 1'b1;
    op_adr[m][i] = adr;
    op_dat[m][i] = word;
    mirror[adr]  = word;
  endtask

  task automatic plan_read(input int m, input int i, input wb_addr_t adr);
    op_we[m][i]   = 1'b0;
    op_adr[m][i]  = adr;
    op_dat[m][i]  = '0;
    exp_dat[m][i] = mirror[adr];
  endtask

  // Runs one bus cycle of n pipelined requests and samples on the falling edge
  task automatic run_burst(input int m, input int n);
    int      issued;
    int      acked;
    int      cycles;
    wb_rsp_t rsp;
    issued = 0;
    acked  = 0;
    cycles = 0;
    late_stalls[m] = 0;
    @(posedge clk);
    drive_req(m, make_req(m, 0));
    while (acked < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > BUS_TIMEOUT) begin
        abort_test($sformatf("Timeout: master %0d got %0d of %0d acks", m, acked, n));
      end
      rsp = rsp_of(m);
      if (rsp.ack) begin
        if (acked >= issued) begin
          abort_test($sformatf("Master %0d got an ack with no request in flight", m));
        end
        if (acked == 0) first_ack_t[m] = $time;
        if (!op_we[m][acked]) begin
          check_data($sformatf("m%0d_rsp_o.dat", m), rsp.dat, exp_dat[m][acked]);
        end
        acked++;
      end
      if (issued < n) begin
        if (!rsp.stall) begin  // Taken at the next edge
          if (issued == 0) first_acc_t[m] = $time;
          issued++;
        end else if (issued > 0) begin
          late_stalls[m]++;
        end
      end
      @(posedge clk);
      if (acked == n) begin
        drive_req(m, '0);
        done_t[m] = $time;
      end else if (issued < n) begin
        drive_req(m, make_req(m, issued));
      end else begin
        drive_req(m, '{cyc: 1'b1, stb: 1'b0, we: 1'b0, adr: '0, dat: '0});
      end
    end
    @(negedge clk);
    rsp = rsp_of(m);
    check_bit($sformatf("m%0d_rsp_o.ack after last ack", m), rsp.ack, 1'b0);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) abort_test("Reset was never released");
    end while (rst);
  endtask

  task automatic idle_outputs_after_reset();
    wb_rsp_t rsp;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      rsp = rsp_of(m);
      check_bit($sformatf("m%0d_rsp_o.ack", m), rsp.ack, 1'b0);
      check_bit($sformatf("m%0d_rsp_o.stall", m), rsp.stall, 1'b1);
    end
  endtask

  task automatic write_read_each_master();
    for (int m = 0; m < NUM_MASTERS; m++) begin
      plan_write(m, 0, wb_addr_t'(8'h10 + m));
      run_burst(m, 1);
      plan_read(m, 0, wb_addr_t'(8'h10 + m));
      run_burst(m, 1);
    end
  endtask

  task automatic pipelined_write_read_burst();
    for (int i = 0; i < 4; i++) plan_write(1, i, wb_addr_t'(8'h40 + i));
    for (int i = 0; i < 4; i++) plan_read(1, i + 4, wb_addr_t'(8'h40 + i));
    run_burst(1, 8);
    check_count("m1 stalls inside burst", late_stalls[1], 0);  // One request per cycle
  endtask

  task automatic read_right_after_write();
    plan_write(0, 0, 8'h55);
    plan_read(0, 1, 8'h55);
    run_burst(0, 2);
    check_count("m0 hazard stalls", late_stalls[0], 1);
  endtask

  task automatic contend_all_masters();
    for (int m = 0; m < NUM_MASTERS; m++) begin
      plan_write(m, 0, wb_addr_t'(8'h20 + m));
      plan_read(m, 1, wb_addr_t'(8'h20 + m));
    end
    fork
      run_burst(0, 2);
      run_burst(1, 2);
      run_burst(2, 2);
    join
    if (!(first_ack_t[0] < first_ack_t[1] && first_ack_t[1] < first_ack_t[2])) begin
      abort_test("Acks did not arrive in the order master 0, master 1, master 2");
    end
    // A waiting master only gets stall low after the previous owner leaves
    if (first_acc_t[1] <= done_t[0] || first_acc_t[2] <= done_t[1]) begin
      abort_test("A waiting master saw stall low while another master owned the bus");
    end
  endtask

  task automatic request_during_burst();
    for (int i = 0; i < 4; i++) plan_write(2, i, wb_addr_t'(8'h30 + i));
    plan_read(0, 0, 8'h33);  // Sees the last word of the burst
    fork
      run_burst(2, 4);
      begin
        repeat (3) @(posedge clk);
        run_burst(0, 1);
      end
    join
    if (first_acc_t[0] <= done_t[2] || first_ack_t[0] <= done_t[2]) begin
      abort_test("Master 0 was served before master 2 dropped cyc");
    end
  endtask

  initial begin
    m0_req <= '0;
    m1_req <= '0;
    m2_req <= '0;
    wait_reset_release();
    idle_outputs_after_reset();
    write_read_each_master();
    pipelined_write_read_burst();
    read_right_after_write();
    contend_all_masters();
    request_during_burst();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: wb_sys_top.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/wb_priority_arbiter.sv
hdl/wb_sram_slave.sv
hdl/wb_sys_top.sv
testbench/tb_clock_gen.sv
testbench/tb_wb_sys_top.sv
